// File: dv/cif_reg_testdata.txt
# op target data expected; expected is hex read data, X or - for no response
# W readback with expected; S target 1xx stat0 2xx stat1 3xx chain mon 4xx ch mon; E target chain
W 0800 a5a50000 a5a50000
W 0804 a5a50001 a5a50001
W 0808 a5a50010 a5a50010
W 080c a5a50011 a5a50011
W 0810 a5a50020 a5a50020
W 0814 a5a50021 a5a50021
W 0818 a5a50030 a5a50030
W 081c a5a50031 a5a50031
O 0814 0 a5a50021
O 0818 0 a5a50030
W 0880 0000003e 00000006
O 0880 0 6
W 1800 c0ffee11 c0ffee11
O 1800 0 c0ffee11
W 1850 0000000d 00000005
R 0888 0 00000000
R 19fc 0 00000000
R 2000 0 X
R 0a00 0 X
S 0102 12345678 -
S 0203 9abcdef0 -
R 0980 0 12345678
R 09c4 0 9abcdef0
S 0405 00c0ffee -
S 0404 0badf00d -
S 0302 0000beef -
S 0301 11111111 -
R 1854 0 00c0ffee
R 1840 0 0000beef
E 1 00000030 -
O 09e8 0 00000030
O 09e0 0 1
R 09e0 0 00000001
R 09e8 0 00000030
W 09f4 0000ff00 0000ff00
O 09f4 0 0000ff00
E 2 0000ff01 -
O 09ec 0 00000001
W 09e0 00000000 -
O 09e0 0 1
W 09e0 00000001 -
O 09e8 0 0
O 09ec 0 0
O 09e0 0 0
R 09e0 0 00000000

// File: verilog.f
design/cif_cfg_pkg.sv
design/cif_map_pkg.sv
design/cif_req_decode.sv
design/cif_ctrl_regs.sv
design/cif_err_latch.sv
design/cif_status_mon.sv
design/cif_read_mux.sv
design/cif_reg_top.sv
dv/cif_reg_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := cif_reg_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/cif_reg_tb.sv
/*
  Testbench for the DMA register interface block.
  Replays dv/cif_reg_testdata.txt line by line against cif_reg_top,
  checks read responses, control outputs and the sticky error state.
  Run from the project root so the data file path resolves.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_reg_tb;

  import cif_cfg_pkg::*;
  import cif_map_pkg::*;

  localparam int CH_NUM    = 8;
  localparam int CHAIN_NUM = 4;
  localparam int unsigned SEED = 32'h3524_b40f;

  typedef logic [8*16-1:0] tok_t;  // one whitespace-separated field

  logic  user_clk = 1'b0;
  logic  reset_n;
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  logic  rep_valid;
  data_t rep_data;
  data_t chain_ctrl0 [CHAIN_NUM-1:0];
  data_t chain_ctrl1 [CHAIN_NUM-1:0];
  mode_t mode;
  data_t glb_ctrl;
  data_t err_mask;
  logic  err_any;
  data_t err_chain   [CHAIN_NUM-1:0];
  data_t chain_err   [CHAIN_NUM-1:0];
  data_t chain_stat0 [CHAIN_NUM-1:0];
  data_t chain_stat1 [CHAIN_NUM-1:0];
  data_t chain_mon   [CHAIN_NUM-1:0];
  data_t ch_mon      [CH_NUM-1:0];

  // parsed test lines
  logic [7:0] line_op [$];
  addr_t      line_tgt [$];
  data_t      line_dat [$];
  data_t      line_exp [$];
  bit         line_has [$];

  data_t exp_q [$];      // read data still owed by the DUT
  addr_t rd_addr_q [$];
  int    rep_count      = 0;
  int    reads_expected = 0;
  int    cycle_cnt      = 0;
  int    cycle_limit    = 0;

  always #10 user_clk = ~user_clk;

  cif_reg_top #(.CH_NUM(CH_NUM), .CHAIN_NUM(CHAIN_NUM)) cif_reg_top_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_req_valid (req_valid), .i_req_write (req_write),
    .i_req_addr (req_addr), .i_req_wdata (req_wdata),
    .o_rep_valid (rep_valid), .o_rep_data (rep_data),
    .o_chain_ctrl0 (chain_ctrl0), .o_chain_ctrl1 (chain_ctrl1),
    .o_mode (mode), .o_glb_ctrl (glb_ctrl), .o_err_mask (err_mask),
    .o_err_any (err_any), .o_err_chain (err_chain),
    .i_chain_err (chain_err), .i_chain_stat0 (chain_stat0),
    .i_chain_stat1 (chain_stat1), .i_chain_mon (chain_mon), .i_ch_mon (ch_mon)
  );

  task automatic end_with_failure();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_mode(input mode_t got, input mode_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic load_testdata();
    int                fd;
    int                cnt;
    logic [8*128-1:0]  line;
    tok_t              op_tok;
    tok_t              exp_tok;
    addr_t             tgt;
    data_t             dat;
    data_t             expv;
    fd = $fopen("dv/cif_reg_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open dv/cif_reg_testdata.txt");
      end_with_failure();
    end
    while (!$feof(fd)) begin
      line    = '0;
      op_tok  = '0;
      exp_tok = '0;
      expv    = '0;
      cnt = $fgets(line, fd);
      if (cnt > 0) cnt = $sscanf(line, "%s %h %h %s", op_tok, tgt, dat, exp_tok);
      if (cnt >= 1 && op_tok != tok_t'("#")) begin
        if (cnt != 4 || op_tok[8*16-1:8] != '0) begin
          $display("ERROR: malformed test line after %0d good lines", line_op.size());
          end_with_failure();
        end
        line_op.push_back(op_tok[7:0]);
        line_tgt.push_back(tgt);
        line_dat.push_back(dat);
        if (exp_tok == tok_t'("X") || exp_tok == tok_t'("-")) begin
          line_has.push_back(1'b0);
        end else begin
          cnt = $sscanf(exp_tok, "%h", expv);
          line_has.push_back(1'b1);
        end
        line_exp.push_back(expv);
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_req(input logic wr, input addr_t a, input data_t d);
    @(posedge user_clk);
    req_valid <= 1'b1;
    req_write <= wr;
    req_addr  <= a;
    req_wdata <= d;
    @(posedge user_clk);
    req_valid <= 1'b0;
    repeat (3) @(posedge user_clk);  // any owed response has landed by now
    if (exp_q.size() != 0) begin
      $display("ERROR: no response pulse for the read of %h", a);
      end_with_failure();
    end
  endtask

  task automatic pulse_error(input int chain, input data_t bits);
    @(posedge user_clk);
    chain_err[chain] <= bits;
    @(posedge user_clk);
    chain_err[chain] <= '0;
    repeat (2) @(posedge user_clk);
  endtask

  // target 1xx stat0, 2xx stat1, 3xx chain monitor, 4xx channel monitor
  task automatic drive_input(input addr_t tgt, input data_t val);
    int idx;
    idx = int'(tgt[7:0]);
    @(posedge user_clk);
    case (tgt[15:8])
      8'h01: chain_stat0[idx] <= val;
      8'h02: chain_stat1[idx] <= val;
      8'h03: chain_mon[idx]   <= val;
      8'h04: ch_mon[idx]      <= val;
      default: begin
        $display("ERROR: unknown input target %h in test data", tgt);
        end_with_failure();
      end
    endcase
    repeat (2) @(posedge user_clk);  // sampled one cycle behind
  endtask

  // writable registers that also drive a top-level output port
  function automatic bit has_output_port(input addr_t a);
    bit in_ctrl;
    in_ctrl = a >= ADDR_CHAIN_CTRL_BASE && a < ADDR_CHAIN_CTRL_BASE + addr_t'(8 * CHAIN_NUM);
    return in_ctrl || a == ADDR_MODE || a == ADDR_GLB_CTRL || a == ADDR_ERR_MASK;
  endfunction

  task automatic verify_output(input addr_t a, input data_t e);
    int idx;
    @(negedge user_clk);
    if (a >= ADDR_CHAIN_CTRL_BASE && a < ADDR_CHAIN_CTRL_BASE + addr_t'(8 * CHAIN_NUM)) begin
      idx = int'((a - ADDR_CHAIN_CTRL_BASE) >> 3);  // stride 8 with ctrl1 at +4
      if (a[2]) check_data(chain_ctrl1[idx], e, $sformatf("o_chain_ctrl1[%0d]", idx));
      else check_data(chain_ctrl0[idx], e, $sformatf("o_chain_ctrl0[%0d]", idx));
    end else if (a >= ADDR_ERR_CHAIN_BASE && a < ADDR_ERR_MASK) begin
      idx = int'((a - ADDR_ERR_CHAIN_BASE) >> 2);
      check_data(err_chain[idx], e, $sformatf("o_err_chain[%0d]", idx));
    end else begin
      case (a)
        ADDR_MODE:     check_mode(mode, e[2:0], "o_mode");
        ADDR_GLB_CTRL: check_data(glb_ctrl, e, "o_glb_ctrl");
        ADDR_ERR_MASK: check_data(err_mask, e, "o_err_mask");
        ADDR_ERR_SUM:  check_bit(err_any, e[0], "o_err_any");
        default: begin
          $display("ERROR: no output port for address %h", a);
          end_with_failure();
        end
      endcase
    end
  endtask

  // response monitor sampled mid-cycle
  always @(negedge user_clk) begin
    if (reset_n && rep_valid) begin
      rep_count++;
      if (exp_q.size() == 0) begin
        $display("ERROR: response pulse at %0d ns with no read pending", $time);
        end_with_failure();
      end else begin
        check_data(rep_data, exp_q.pop_front(), $sformatf("read of %h", rd_addr_q.pop_front()));
      end
    end
  end

  always @(posedge user_clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: timeout after %0d cycles", cycle_cnt);
      end_with_failure();
    end
  end

  initial begin
    void'($urandom(SEED));
    reset_n   = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    for (int i = 0; i < CHAIN_NUM; i++) begin
      chain_err[i]   = '0;
      chain_stat0[i] = '0;
      chain_stat1[i] = '0;
      chain_mon[i]   = '0;
    end
    for (int i = 0; i < CH_NUM; i++) ch_mon[i] = '0;
    load_testdata();
    if (line_op.size() == 0) begin
      $display("ERROR: test data file holds no lines");
      end_with_failure();
    end
    cycle_limit = 20 * line_op.size();
    repeat (10) @(posedge user_clk);
    reset_n <= 1'b1;
    repeat (2) @(posedge user_clk);
    for (int i = 0; i < line_op.size(); i++) begin
      case (line_op[i])
        "W": begin
          issue_req(1'b1, line_tgt[i], line_dat[i]);
          if (line_has[i]) begin  // read back what was written
            exp_q.push_back(line_exp[i]);
            rd_addr_q.push_back(line_tgt[i]);
            reads_expected++;
            issue_req(1'b0, line_tgt[i], '0);
            if (has_output_port(line_tgt[i])) begin
              verify_output(line_tgt[i], line_exp[i]);  // port shows the same value
            end
          end
        end
        "R": begin
          if (line_has[i]) begin
            exp_q.push_back(line_exp[i]);
            rd_addr_q.push_back(line_tgt[i]);
            reads_expected++;
          end
          issue_req(1'b0, line_tgt[i], '0);
        end
        "E": pulse_error(int'(line_tgt[i]), line_dat[i]);
        "S": drive_input(line_tgt[i], line_dat[i]);
        "O": verify_output(line_tgt[i], line_exp[i]);
        default: begin
          $display("ERROR: unknown opcode letter in test line %0d", i + 1);
          end_with_failure();
        end
      endcase
    end
    repeat (4) @(posedge user_clk);
    if (exp_q.size() != 0 || rep_count != reads_expected) begin
      $display("ERROR: %0d response pulses seen, %0d expected", rep_count, reads_expected);
      end_with_failure();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: design/cif_reg_top.sv
/*
  Register interface block for the multi-chain DMA engine.
  Host issues single-cycle read/write strobes; reads inside the map
  windows are answered two cycles after the request is sampled.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_reg_top #(
  parameter int CH_NUM    = cif_cfg_pkg::DEF_CH_NUM,
  parameter int CHAIN_NUM = cif_cfg_pkg::DEF_CHAIN_NUM
)(
  input  wire                  user_clk,
  input  wire                  reset_n,
  input  wire                  i_req_valid,
  input  wire                  i_req_write,
  input  cif_cfg_pkg::addr_t   i_req_addr,
  input  cif_cfg_pkg::data_t   i_req_wdata,
  output logic                 o_rep_valid,
  output cif_cfg_pkg::data_t   o_rep_data,
  output cif_cfg_pkg::data_t   o_chain_ctrl0 [CHAIN_NUM-1:0],
  output cif_cfg_pkg::data_t   o_chain_ctrl1 [CHAIN_NUM-1:0],
  output cif_cfg_pkg::mode_t   o_mode,
  output cif_cfg_pkg::data_t   o_glb_ctrl,
  output cif_cfg_pkg::data_t   o_err_mask,
  output logic                 o_err_any,
  output cif_cfg_pkg::data_t   o_err_chain   [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t   i_chain_err   [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t   i_chain_stat0 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t   i_chain_stat1 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t   i_chain_mon   [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t   i_ch_mon      [CH_NUM-1:0]
);

  import cif_cfg_pkg::*;
  import cif_map_pkg::*;

  cif_op_e                   op;
  addr_t                     addr;
  data_t                     wdata;
  logic [$clog2(CH_NUM)-1:0] ch_sel;
  data_t                     stat0 [CHAIN_NUM-1:0];
  data_t                     stat1 [CHAIN_NUM-1:0];
  data_t                     chain_mon_sel;
  data_t                     ch_mon_sel;

  cif_req_decode cif_req_decode_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_req_valid (i_req_valid), .i_req_write (i_req_write),
    .i_req_addr (i_req_addr), .i_req_wdata (i_req_wdata),
    .o_op (op), .o_addr (addr), .o_wdata (wdata)
  );

  cif_ctrl_regs #(.CH_NUM(CH_NUM), .CHAIN_NUM(CHAIN_NUM)) cif_ctrl_regs_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_op (op), .i_addr (addr), .i_wdata (wdata),
    .o_chain_ctrl0 (o_chain_ctrl0), .o_chain_ctrl1 (o_chain_ctrl1),
    .o_mode (o_mode), .o_glb_ctrl (o_glb_ctrl),
    .o_err_mask (o_err_mask), .o_ch_sel (ch_sel)
  );

  cif_err_latch #(.CHAIN_NUM(CHAIN_NUM)) cif_err_latch_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_op (op), .i_addr (addr), .i_wdata (wdata),
    .i_chain_err (i_chain_err), .i_err_mask (o_err_mask),
    .o_err_chain (o_err_chain), .o_err_any (o_err_any)
  );

  cif_status_mon #(.CH_NUM(CH_NUM), .CHAIN_NUM(CHAIN_NUM)) cif_status_mon_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_ch_sel (ch_sel),
    .i_chain_stat0 (i_chain_stat0), .i_chain_stat1 (i_chain_stat1),
    .i_chain_mon (i_chain_mon), .i_ch_mon (i_ch_mon),
    .o_stat0 (stat0), .o_stat1 (stat1),
    .o_chain_mon_sel (chain_mon_sel), .o_ch_mon_sel (ch_mon_sel)
  );

  cif_read_mux #(.CH_NUM(CH_NUM), .CHAIN_NUM(CHAIN_NUM)) cif_read_mux_i (
    .user_clk (user_clk), .reset_n (reset_n),
    .i_op (op), .i_addr (addr),
    .i_chain_ctrl0 (o_chain_ctrl0), .i_chain_ctrl1 (o_chain_ctrl1),
    .i_mode (o_mode), .i_glb_ctrl (o_glb_ctrl), .i_err_mask (o_err_mask),
    .i_ch_sel (ch_sel), .i_err_chain (o_err_chain), .i_err_any (o_err_any),
    .i_stat0 (stat0), .i_stat1 (stat1),
    .i_chain_mon_sel (chain_mon_sel), .i_ch_mon_sel (ch_mon_sel),
    .o_rep_valid (o_rep_valid), .o_rep_data (o_rep_data)
  );

endmodule

`default_nettype wire

// File: design/cif_read_mux.sv
/*
  Read data selection and response pipeline.
  A decoded read picks its word through the address map; data and
  the window check are registered, then issued as the response pulse.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_read_mux #(
  parameter int CH_NUM    = cif_cfg_pkg::DEF_CH_NUM,
  parameter int CHAIN_NUM = cif_cfg_pkg::DEF_CHAIN_NUM
)(
  input  wire                        user_clk,
  input  wire                        reset_n,
  input  cif_map_pkg::cif_op_e       i_op,
  input  cif_cfg_pkg::addr_t         i_addr,
  input  cif_cfg_pkg::data_t         i_chain_ctrl0 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_chain_ctrl1 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::mode_t         i_mode,
  input  cif_cfg_pkg::data_t         i_glb_ctrl,
  input  cif_cfg_pkg::data_t         i_err_mask,
  input  wire [$clog2(CH_NUM)-1:0]   i_ch_sel,
  input  cif_cfg_pkg::data_t         i_err_chain   [CHAIN_NUM-1:0],
  input  wire                        i_err_any,
  input  cif_cfg_pkg::data_t         i_stat0       [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_stat1       [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_chain_mon_sel,
  input  cif_cfg_pkg::data_t         i_ch_mon_sel,
  output logic                       o_rep_valid,
  output cif_cfg_pkg::data_t         o_rep_data
);

  import cif_cfg_pkg::*;
  import cif_map_pkg::*;

  data_t rd_word;
  data_t rdata_ff;
  logic  rvalid_ff;

  always_comb begin
    rd_word = '0;  // unmapped reads return zero
    for (int i = 0; i < CHAIN_NUM; i++) begin
      if (i_addr == ADDR_CHAIN_CTRL_BASE + addr_t'(CHAIN_CTRL_STRIDE * i))
        rd_word = i_chain_ctrl0[i];
      if (i_addr == ADDR_CHAIN_CTRL_BASE + addr_t'(CHAIN_CTRL_STRIDE * i + CTRL1_OFS))
        rd_word = i_chain_ctrl1[i];
      if (i_addr == ADDR_CHAIN_STAT_BASE + addr_t'(CHAIN_STAT_STRIDE * i))
        rd_word = i_stat0[i];
      if (i_addr == ADDR_CHAIN_STAT_BASE + addr_t'(CHAIN_STAT_STRIDE * i + STAT1_OFS))
        rd_word = i_stat1[i];
      if (i_addr == ADDR_ERR_CHAIN_BASE + addr_t'(ERR_CHAIN_STRIDE * i))
        rd_word = i_err_chain[i];
    end
    case (i_addr)
      ADDR_MODE:      rd_word = data_t'(i_mode);
      ADDR_ERR_SUM:   rd_word = data_t'(i_err_any);  // summary in bit 0
      ADDR_ERR_MASK:  rd_word = i_err_mask;
      ADDR_GLB_CTRL:  rd_word = i_glb_ctrl;
      ADDR_CHAIN_MON: rd_word = i_chain_mon_sel;
      ADDR_CH_SEL:    rd_word = data_t'(i_ch_sel);
      ADDR_CH_MON:    rd_word = i_ch_mon_sel;
      default: ;
    endcase
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      rdata_ff    <= '0;
      rvalid_ff   <= 1'b0;
      o_rep_valid <= 1'b0;
      o_rep_data  <= '0;
    end else begin
      rdata_ff    <= (i_op == OP_READ) ? rd_word : '0;
      rvalid_ff   <= (i_op == OP_READ) && in_rep_window(i_addr);
      o_rep_valid <= rvalid_ff;  // second stage, pulse and data together
      o_rep_data  <= rdata_ff;
    end
  end

endmodule

`default_nettype wire

// File: design/cif_status_mon.sv
/*
  Status and monitor sampling.
  Every chain's status words are registered each cycle, along with
  the monitor of the selected channel and of the chain it belongs to.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_status_mon #(
  parameter int CH_NUM    = cif_cfg_pkg::DEF_CH_NUM,
  parameter int CHAIN_NUM = cif_cfg_pkg::DEF_CHAIN_NUM
)(
  input  wire                        user_clk,
  input  wire                        reset_n,
  input  wire [$clog2(CH_NUM)-1:0]   i_ch_sel,
  input  cif_cfg_pkg::data_t         i_chain_stat0 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_chain_stat1 [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_chain_mon   [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t         i_ch_mon      [CH_NUM-1:0],
  output cif_cfg_pkg::data_t         o_stat0       [CHAIN_NUM-1:0],
  output cif_cfg_pkg::data_t         o_stat1       [CHAIN_NUM-1:0],
  output cif_cfg_pkg::data_t         o_chain_mon_sel,
  output cif_cfg_pkg::data_t         o_ch_mon_sel
);

  localparam int CH_W    = $clog2(CH_NUM);
  localparam int CHAIN_W = $clog2(CHAIN_NUM);

  // channels split evenly over chains, top bits pick the chain
  logic [CHAIN_W-1:0] chain_sel;

  assign chain_sel = i_ch_sel[CH_W-1 -: CHAIN_W];

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < CHAIN_NUM; i++) begin
        o_stat0[i] <= '0;
        o_stat1[i] <= '0;
      end
      o_chain_mon_sel <= '0;
      o_ch_mon_sel    <= '0;
    end else begin
      o_stat0         <= i_chain_stat0;
      o_stat1         <= i_chain_stat1;
      o_chain_mon_sel <= i_chain_mon[chain_sel];
      o_ch_mon_sel    <= i_ch_mon[i_ch_sel];
    end
  end

endmodule

`default_nettype wire

// File: design/cif_err_latch.sv
/*
  Sticky per-chain error capture.
  Unmasked error bits accumulate while no write is decoded; the
  summary bit follows the sticky words one edge later. Writing 1 to
  bit 0 of the summary register clears everything.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_err_latch #(
  parameter int CHAIN_NUM = cif_cfg_pkg::DEF_CHAIN_NUM
)(
  input  wire                   user_clk,
  input  wire                   reset_n,
  input  cif_map_pkg::cif_op_e  i_op,
  input  cif_cfg_pkg::addr_t    i_addr,
  input  cif_cfg_pkg::data_t    i_wdata,
  input  cif_cfg_pkg::data_t    i_chain_err [CHAIN_NUM-1:0],
  input  cif_cfg_pkg::data_t    i_err_mask,
  output cif_cfg_pkg::data_t    o_err_chain [CHAIN_NUM-1:0],
  output logic                  o_err_any
);

  import cif_cfg_pkg::*;
  import cif_map_pkg::*;

  data_t sticky_or;

  always_comb begin
    sticky_or = '0;
    for (int i = 0; i < CHAIN_NUM; i++) begin
      sticky_or = sticky_or | o_err_chain[i];
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < CHAIN_NUM; i++) o_err_chain[i] <= '0;
      o_err_any <= 1'b0;
    end else if (i_op == OP_WRITE && i_addr == ADDR_ERR_SUM && i_wdata[0]) begin
      for (int i = 0; i < CHAIN_NUM; i++) o_err_chain[i] <= '0;  // write-one-to-clear
      o_err_any <= 1'b0;
    end else begin
      if (i_op != OP_WRITE) begin
        for (int i = 0; i < CHAIN_NUM; i++) begin
          o_err_chain[i] <= o_err_chain[i] | (i_chain_err[i] & ~i_err_mask);
        end
      end
      o_err_any <= |sticky_or;  // one edge behind the sticky words
    end
  end

endmodule

`default_nettype wire

// File: design/cif_ctrl_regs.sv
/*
  Writable control registers: per-chain ctrl0/ctrl1, mode field,
  global control, error mask and channel select.
  Updated on a decoded write whose address matches.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_ctrl_regs #(
  parameter int CH_NUM    = cif_cfg_pkg::DEF_CH_NUM,
  parameter int CHAIN_NUM = cif_cfg_pkg::DEF_CHAIN_NUM
)(
  input  wire                        user_clk,
  input  wire                        reset_n,
  input  cif_map_pkg::cif_op_e       i_op,
  input  cif_cfg_pkg::addr_t         i_addr,
  input  cif_cfg_pkg::data_t         i_wdata,
  output cif_cfg_pkg::data_t         o_chain_ctrl0 [CHAIN_NUM-1:0],
  output cif_cfg_pkg::data_t         o_chain_ctrl1 [CHAIN_NUM-1:0],
  output cif_cfg_pkg::mode_t         o_mode,
  output cif_cfg_pkg::data_t         o_glb_ctrl,
  output cif_cfg_pkg::data_t         o_err_mask,
  output logic [$clog2(CH_NUM)-1:0]  o_ch_sel
);

  import cif_cfg_pkg::*;
  import cif_map_pkg::*;

  localparam int CH_W = $clog2(CH_NUM);

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < CHAIN_NUM; i++) begin
        o_chain_ctrl0[i] <= '0;
        o_chain_ctrl1[i] <= '0;
      end
      o_mode     <= '0;
      o_glb_ctrl <= '0;
      o_err_mask <= '0;
      o_ch_sel   <= '0;
    end else if (i_op == OP_WRITE) begin
      for (int i = 0; i < CHAIN_NUM; i++) begin
        if (i_addr == ADDR_CHAIN_CTRL_BASE + addr_t'(CHAIN_CTRL_STRIDE * i))
          o_chain_ctrl0[i] <= i_wdata;
        if (i_addr == ADDR_CHAIN_CTRL_BASE + addr_t'(CHAIN_CTRL_STRIDE * i + CTRL1_OFS))
          o_chain_ctrl1[i] <= i_wdata;
      end
      case (i_addr)
        ADDR_MODE:     o_mode     <= i_wdata[$bits(mode_t)-1:0];  // low bits only
        ADDR_GLB_CTRL: o_glb_ctrl <= i_wdata;
        ADDR_ERR_MASK: o_err_mask <= i_wdata;
        ADDR_CH_SEL:   o_ch_sel   <= i_wdata[CH_W-1:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/cif_req_decode.sv
/*
  Request capture stage.
  Registers the host strobe, address and data, and turns the
  valid/write pair into an opcode held for one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module cif_req_decode (
  input  wire                   user_clk,
  input  wire                   reset_n,
  input  wire                   i_req_valid,
  input  wire                   i_req_write,
  input  cif_cfg_pkg::addr_t    i_req_addr,
  input  cif_cfg_pkg::data_t    i_req_wdata,
  output cif_map_pkg::cif_op_e  o_op,
  output cif_cfg_pkg::addr_t    o_addr,
  output cif_cfg_pkg::data_t    o_wdata
);

  import cif_map_pkg::*;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      o_op    <= OP_NONE;
      o_addr  <= '0;
      o_wdata <= '0;
    end else begin
      if (i_req_valid) begin
        o_op <= i_req_write ? OP_WRITE : OP_READ;
      end else begin
        o_op <= OP_NONE;  // idle cycle
      end
      o_addr  <= i_req_addr;
      o_wdata <= i_req_wdata;
    end
  end

endmodule

`default_nettype wire

// File: design/cif_map_pkg.sv
/*
  Register address map and request opcodes for the DMA register block.
  Per-chain registers are addressed from a base plus a chain stride.
*/
`default_nettype none

package cif_map_pkg;

  typedef enum logic [1:0] {
    OP_NONE  = 2'b00,
    OP_READ  = 2'b01,
    OP_WRITE = 2'b10
  } cif_op_e;

  localparam logic [15:0] ADDR_CHAIN_CTRL_BASE = 16'h0800;  // ctrl0, ctrl1 per chain
  localparam logic [15:0] ADDR_MODE            = 16'h0880;
  localparam logic [15:0] ADDR_CHAIN_STAT_BASE = 16'h0900;
  localparam logic [15:0] ADDR_ERR_SUM         = 16'h09e0;
  localparam logic [15:0] ADDR_ERR_CHAIN_BASE  = 16'h09e4;
  localparam logic [15:0] ADDR_ERR_MASK        = 16'h09f4;
  localparam logic [15:0] ADDR_GLB_CTRL        = 16'h1800;
  localparam logic [15:0] ADDR_CHAIN_MON       = 16'h1840;
  localparam logic [15:0] ADDR_CH_SEL          = 16'h1850;
  localparam logic [15:0] ADDR_CH_MON          = 16'h1854;

  localparam int CHAIN_CTRL_STRIDE = 8;
  localparam int CTRL1_OFS         = 4;
  localparam int CHAIN_STAT_STRIDE = 'h40;
  localparam int STAT1_OFS         = 4;
  localparam int ERR_CHAIN_STRIDE  = 4;

  // 0x08xx-0x09xx and 0x18xx-0x19xx answer reads
  function automatic logic in_rep_window(logic [15:0] addr);
    return (addr[15:13] == 3'b000) && (addr[11:9] == 3'b100);
  endfunction

endpackage

`default_nettype wire

// File: design/cif_cfg_pkg.sv
/*
  Shared widths and word types for the DMA register interface.
  Default chain and channel counts feed the top-level parameters.
*/
`default_nettype none

package cif_cfg_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int MODE_W = 3;

  typedef logic [DATA_W-1:0] data_t;  // one register word
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [MODE_W-1:0] mode_t;

  // default sizing, overridden from the top
  localparam int DEF_CH_NUM    = 32;
  localparam int DEF_CHAIN_NUM = 4;

endpackage

`default_nettype wire
